// ==== Bender.yml ====
package:
  name: cpu_cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/line_cache.sv
      - design/ram_sequencer.sv
      - design/cpu_port.sv
      - design/cpu_cache_top.sv
  - target: simulation
    files:
      - testbench/ram_model.sv
      - testbench/cache_tb.sv

// ==== design/cache_pkg.sv ====
package cache_pkg;

   // the cache has 64 direct-mapped lines of four 16 bit words each
   localparam int line_bits  = 6;
   localparam int line_count = 1 << line_bits;

   // the cpu address counts 16 bit words
   localparam int addr_bits  = 23;

   // the two word select bits and the index bits are not kept in the tag
   localparam int tag_bits   = addr_bits - 2 - line_bits;

   // one cpu bus request, captured while req is high
   // ds bit 0 selects the upper byte and ds bit 1 the lower byte
   typedef struct packed {
      logic [addr_bits-1:0] addr;
      logic                 we;
      logic [1:0]           ds;
      logic [15:0]          wdata;
   } cpu_req_t;

   // the two things the ram bus is ever asked to do
   typedef enum logic {
      ram_read_line,
      ram_write_word
   } ram_op_e;

   // ram command, addr is the word address without the word select
   // a line read ignores word, ds and wdata
   typedef struct packed {
      logic                 strobe;
      ram_op_e              op;
      logic [addr_bits-3:0] addr;
      logic [1:0]           word;
      logic [1:0]           ds;
      logic [15:0]          wdata;
   } ram_req_t;

   typedef enum logic [2:0] {idle, lookup, compare, fill, write} cpu_state_e;

   typedef enum logic {ram_idle, ram_wait} ram_state_e;

endpackage

// ==== design/cpu_cache_top.sv ====
`timescale 1ns/1ns

module cpu_cache_top (
   input  logic                clk_128,
   input  logic                rst_n,
   input  logic                flush,
   input  logic                req,
   input  cache_pkg::cpu_req_t req_data,
   output logic                busy,
   output logic                done,
   output logic [15:0]         rdata,
   output cache_pkg::ram_req_t ram_cmd,
   input  logic                ram_ack,
   input  logic [63:0]         ram_rdata
);
   import cache_pkg::*;

   // cpu port to cache
   logic [addr_bits-1:0] lookup_addr;
   logic [1:0]           cache_ds;
   logic [15:0]          din16;
   logic                 upd;
   logic                 hit;
   logic [15:0]          dout;

   // cpu port to ram sequencer and back
   logic                 fetch;
   logic                 wr;
   logic                 fill_done;
   logic                 wr_done;
   cpu_req_t             seq_req;

   // ram sequencer to cache
   logic                 store;
   logic [63:0]          din64;

   // the captured request reaches the sequencer through the cache-side signals
   assign seq_req = '{addr: lookup_addr, we: wr, ds: cache_ds, wdata: din16};

   cpu_port port_i (
      .clk_128(clk_128), .rst_n(rst_n), .req(req), .req_data(req_data),
      .busy(busy), .done(done), .rdata(rdata), .lookup_addr(lookup_addr),
      .ds(cache_ds), .din16(din16), .upd(upd), .hit(hit), .dout(dout),
      .fetch(fetch), .wr(wr), .fill_done(fill_done), .wr_done(wr_done)
   );

   line_cache cache_i (
      .clk_128(clk_128), .rst_n(rst_n), .flush(flush), .lookup_addr(lookup_addr),
      .ds(cache_ds), .din16(din16), .upd(upd), .store(store), .din64(din64),
      .hit(hit), .dout(dout)
   );

   ram_sequencer seq_i (
      .clk_128(clk_128), .rst_n(rst_n), .fetch(fetch), .wr(wr), .req_data(seq_req),
      .ram_cmd(ram_cmd), .ram_ack(ram_ack), .ram_rdata(ram_rdata), .store(store),
      .din64(din64), .fill_done(fill_done), .wr_done(wr_done)
   );

endmodule

// ==== design/cpu_port.sv ====
`timescale 1ns/1ns

module cpu_port (
   input  logic                            clk_128,
   input  logic                            rst_n,
   input  logic                            req,
   input  cache_pkg::cpu_req_t             req_data,
   output logic                            busy,
   output logic                            done,
   output logic [15:0]                     rdata,
   output logic [cache_pkg::addr_bits-1:0] lookup_addr,
   output logic [1:0]                      ds,
   output logic [15:0]                     din16,
   output logic                            upd,
   input  logic                            hit,
   input  logic [15:0]                     dout,
   output logic                            fetch,
   output logic                            wr,
   input  logic                            fill_done,
   input  logic                            wr_done
);
   import cache_pkg::*;

   cpu_state_e state;
   cpu_state_e state_nxt;
   cpu_req_t   req_q;

   // the captured request is taken only in idle, so it stays put until done
   always_ff @(posedge clk_128) begin
      if (state == idle && req) begin
         req_q <= req_data;
      end
   end

   always_ff @(posedge clk_128) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         state <= state_nxt;
      end
   end

   // lookup gives the cache one cycle to read the line, compare decides
   // after a fill the request goes round through lookup again
   always_comb begin
      state_nxt = state;
      case (state)
         idle:    if (req) state_nxt = lookup;
         lookup:  state_nxt = compare;
         compare: begin
            if (req_q.we) begin
               state_nxt = write;
            end else if (hit) begin
               state_nxt = idle;
            end else begin
               state_nxt = fill;
            end
         end
         fill:    if (fill_done) state_nxt = lookup;
         write:   if (wr_done) state_nxt = idle;
         default: state_nxt = idle;
      endcase
   end

   // the cache always looks at the captured request
   assign lookup_addr = req_q.addr;
   assign ds          = req_q.ds;
   assign din16       = req_q.wdata;

   // strobes toward the cache and the ram sequencer, all from compare
   assign fetch = (state == compare) && !req_q.we && !hit;
   assign wr    = (state == compare) && req_q.we;
   assign upd   = (state == compare) && req_q.we && hit;

   // a read ends on a hit in compare, a write when the ram accepted it
   assign done  = ((state == compare) && !req_q.we && hit) || ((state == write) && wr_done);
   assign rdata = dout;
   assign busy  = (state != idle);

   // the cpu holds off while a request is in flight
   a_no_req_while_busy: assert property (
      @(posedge clk_128) disable iff (!rst_n) req |-> !busy);

endmodule

// ==== design/line_cache.sv ====
`timescale 1ns/1ns

module line_cache (
   input  logic                            clk_128,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic [cache_pkg::addr_bits-1:0] lookup_addr,
   input  logic [1:0]                      ds,
   input  logic [15:0]                     din16,
   input  logic                            upd,
   input  logic                            store,
   input  logic [63:0]                     din64,
   output logic                            hit,
   output logic [15:0]                     dout
);
   import cache_pkg::*;

   // fields of the address currently presented by the cpu port
   logic [line_bits-1:0]  idx;
   logic [tag_bits-1:0]   tag;
   logic [1:0]            word;

   // data store, indexed as line, word and byte with byte 1 the upper byte
   logic [3:0][1:0][7:0]  data_mem [line_count];
   logic [tag_bits-1:0]   tag_mem  [line_count];
   logic [line_count-1:0] valid;

   // address fields registered on the rising edge
   logic [line_bits-1:0]  line_q;
   logic [tag_bits-1:0]   tag_q;
   logic [1:0]            word_q;

   // tag and valid bit read out of the line that line_q points at
   logic [tag_bits-1:0]   tag_rd;
   logic                  valid_rd;

   // word select in the low bits, then the line index, the tag on top
   assign word = lookup_addr[1:0];
   assign idx  = lookup_addr[line_bits+1:2];
   assign tag  = lookup_addr[addr_bits-1:line_bits+2];

   // the lookup is one cycle deep
   // everything below is read from the index of lookup_addr on each edge
   always_ff @(posedge clk_128) begin
      line_q <= idx;
      tag_q  <= tag;
      word_q <= word;
      tag_rd <= tag_mem[idx];
      dout   <= data_mem[idx][word];
   end

   // a hit needs the stored tag of the addressed line to match the request
   assign hit = valid_rd && (tag_rd == tag_q);

   // valid bits clear on the same edge that samples reset or flush
   // valid_rd is cleared there too, so a flushed line cannot hit next cycle
   always_ff @(posedge clk_128) begin
      if (!rst_n || flush) begin
         valid    <= '0;
         valid_rd <= 1'b0;
      end else begin
         if (store) begin
            valid[line_q] <= 1'b1;
         end
         valid_rd <= valid[idx];
      end
   end

   // lookup_addr is held steady by the cpu port during a fill or a write
   // so the registered fields address the line being written
   always_ff @(posedge clk_128) begin
      if (store) begin
         // a fetched line replaces whatever the line held before
         data_mem[line_q] <= din64;
         tag_mem[line_q]  <= tag_q;
      end else if (upd && hit) begin
         // write-through patch, tag and valid stay as they are
         if (ds[1]) begin
            data_mem[line_q][word_q][0] <= din16[7:0];
         end
         if (ds[0]) begin
            data_mem[line_q][word_q][1] <= din16[15:8];
         end
      end
   end

   // fills and cpu writes are separate phases of the cpu port FSM
   a_no_store_with_upd: assert property (
      @(posedge clk_128) disable iff (!rst_n) !(store && upd));

   // a stored line must be seen as a hit by the lookup that follows it
   a_store_then_hit: assert property (
      @(posedge clk_128) disable iff (!rst_n || flush) store |-> ##2 hit);

endmodule

// ==== design/ram_sequencer.sv ====
`timescale 1ns/1ns

module ram_sequencer (
   input  logic                clk_128,
   input  logic                rst_n,
   input  logic                fetch,
   input  logic                wr,
   input  cache_pkg::cpu_req_t req_data,
   output cache_pkg::ram_req_t ram_cmd,
   input  logic                ram_ack,
   input  logic [63:0]         ram_rdata,
   output logic                store,
   output logic [63:0]         din64,
   output logic                fill_done,
   output logic                wr_done
);
   import cache_pkg::*;

   ram_state_e state;
   logic       launch;
   logic       line_read;
   logic       acked;

   // only one command is ever outstanding on the ram bus
   assign launch    = (state == ram_idle) && (fetch || wr);
   assign acked     = (state == ram_wait) && ram_ack;
   assign line_read = (ram_cmd.op == ram_read_line);

   // the line goes into the cache on the ack cycle itself
   assign din64     = ram_rdata;
   assign store     = acked && line_read;
   assign fill_done = acked && line_read;
   assign wr_done   = acked && !line_read;

   always_ff @(posedge clk_128) begin
      // command payload, held stable until the next launch
      if (launch) begin
         ram_cmd.op    <= fetch ? ram_read_line : ram_write_word;
         ram_cmd.addr  <= req_data.addr[addr_bits-1:2];
         ram_cmd.word  <= fetch ? 2'd0 : req_data.addr[1:0];
         ram_cmd.ds    <= req_data.ds;
         ram_cmd.wdata <= req_data.wdata;
      end
      if (!rst_n) begin
         state          <= ram_idle;
         ram_cmd.strobe <= 1'b0;
      end else begin
         // strobe is high for the one cycle after launch
         ram_cmd.strobe <= launch;
         if (launch) begin
            state <= ram_wait;
         end else if (acked) begin
            state <= ram_idle;
         end
      end
   end

   // the cpu port never asks for a new transfer before the last one ended
   a_cmd_only_when_idle: assert property (
      @(posedge clk_128) disable iff (!rst_n) (fetch || wr) |-> state == ram_idle);

   // the ram answers only a command that was actually issued
   a_ack_only_when_waiting: assert property (
      @(posedge clk_128) disable iff (!rst_n) ram_ack |-> state == ram_wait);

endmodule

// ==== project.f ====
design/cache_pkg.sv
design/line_cache.sv
design/ram_sequencer.sv
design/cpu_port.sv
design/cpu_cache_top.sv
testbench/ram_model.sv
testbench/cache_tb.sv

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;
   import cache_pkg::*;

   // expected latency class of the request in flight
   localparam int any_latency = 0;
   localparam int warm        = 1;
   localparam int cold        = 2;
   // about 150 requests at a worst miss of 20 cycles, plus margin
   localparam int cycle_limit = 4000;

   logic        clk_128;
   logic        rst_n;
   logic        flush;
   logic        req;
   cpu_req_t    req_data;
   logic        busy;
   logic        done;
   logic [15:0] rdata;
   ram_req_t    ram_cmd;
   logic        ram_ack;
   logic [63:0] ram_rdata;

   // scoreboard of the request in flight
   cpu_req_t    cur_req;
   int          cur_kind;
   logic [15:0] cur_exp;
   int          lat;
   logic        pending;
   logic        done_q;
   int          cycles = 0;
   integer      seed = 32'he648;

   // shadow memory, plus the line tags that the cache ought to hold
   logic [15:0]           shadow [logic [addr_bits-1:0]];
   logic [tag_bits-1:0]   model_tag [line_count];
   logic [line_count-1:0] model_valid;

   cpu_cache_top dut_i (
      .clk_128(clk_128), .rst_n(rst_n), .flush(flush), .req(req), .req_data(req_data),
      .busy(busy), .done(done), .rdata(rdata), .ram_cmd(ram_cmd), .ram_ack(ram_ack),
      .ram_rdata(ram_rdata)
   );

   ram_model ram_i (
      .clk_128(clk_128), .ram_cmd(ram_cmd), .ram_ack(ram_ack), .ram_rdata(ram_rdata)
   );

   always #50 clk_128 = ~clk_128;

   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic value_error(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
      abort_run();
   endtask

   function automatic logic [15:0] shadow_word(input logic [addr_bits-1:0] a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      // a word never written holds its low address bits xor a fixed pattern
      return a[15:0] ^ 16'h5a5a;
   endfunction

   // ds bit 0 takes the upper byte from wdata, ds bit 1 the lower byte
   function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                               input logic [15:0] wdata,
                                               input logic [1:0]  ds);
      return {ds[0] ? wdata[15:8] : old[15:8], ds[1] ? wdata[7:0] : old[7:0]};
   endfunction

   function automatic logic cached(input logic [addr_bits-1:0] a);
      return model_valid[a[line_bits+1:2]] &&
             (model_tag[a[line_bits+1:2]] == a[addr_bits-1:line_bits+2]);
   endfunction

   // called 1 ns after an edge with busy low, returns once done was seen
   task automatic send(input cpu_req_t r, input int kind, input logic [15:0] expected);
      cur_req  = r;
      cur_kind = kind;
      cur_exp  = expected;
      req_data = r;
      req      = 1'b1;
      @(posedge clk_128);
      #1;
      req = 1'b0;
      while (done_q !== 1'b1) begin
         @(posedge clk_128);
         #1;
      end
   endtask

   task automatic read_word(input logic [addr_bits-1:0] a);
      cpu_req_t r;
      r = '{addr: a, we: 1'b0, ds: 2'b11, wdata: 16'h0000};
      send(r, cached(a) ? warm : cold, shadow_word(a));
      // a read leaves its whole line in the cache
      model_tag[a[line_bits+1:2]]   = a[addr_bits-1:line_bits+2];
      model_valid[a[line_bits+1:2]] = 1'b1;
   endtask

   // writes never allocate a line, so the tag record stays as it is
   task automatic write_word(input logic [addr_bits-1:0] a, input logic [1:0] ds,
                             input logic [15:0] wdata);
      cpu_req_t r;
      r = '{addr: a, we: 1'b1, ds: ds, wdata: wdata};
      shadow[a] = merge_bytes(shadow_word(a), wdata, ds);
      send(r, any_latency, 16'h0000);
   endtask

   task automatic pulse_flush();
      flush = 1'b1;
      @(posedge clk_128);
      #1;
      flush       = 1'b0;
      model_valid = '0;
   endtask

   // lat counts edges since req was sampled, so a hit has lat 2 at done
   always @(posedge clk_128) begin
      cycles <= cycles + 1;
      if (!rst_n) begin
         lat     <= 0;
         pending <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= done;
         if (req) begin
            lat     <= 1;
            pending <= 1'b1;
         end else begin
            if (busy) begin
               lat <= lat + 1;
            end
            if (done) begin
               pending <= 1'b0;
            end
         end
      end
      if (cycles >= cycle_limit) begin
         $display("timeout: the test did not finish within %0d cycles", cycle_limit);
         abort_run();
      end
   end

   a_quiet_after_reset: assert property (@(posedge clk_128) !rst_n |=> !busy && !done)
      else value_error("{busy,done}", 0, {$sampled(busy), $sampled(done)});

   a_read_data: assert property (@(posedge clk_128) disable iff (!rst_n)
      done && !cur_req.we |-> rdata == cur_exp)
      else value_error("rdata", $sampled(cur_exp), $sampled(rdata));

   a_hit_latency: assert property (@(posedge clk_128) disable iff (!rst_n)
      done && cur_kind == warm |-> lat == 2)
      else value_error("done latency", 2, $sampled(lat));

   a_miss_latency: assert property (@(posedge clk_128) disable iff (!rst_n)
      done && cur_kind == cold |-> lat > 2)
      else begin
         $display("a read that should miss finished in %0d cycles", $sampled(lat));
         abort_run();
      end

   a_done_once: assert property (@(posedge clk_128) disable iff (!rst_n) done |-> pending)
      else begin
         $display("done pulsed with no request in flight");
         abort_run();
      end

   a_req_idle: assert property (@(posedge clk_128) disable iff (!rst_n) req |-> !busy)
      else value_error("busy", 0, $sampled(busy));

   // each ram command goes to the line or word of the request in flight
   a_ram_addr: assert property (@(posedge clk_128) disable iff (!rst_n)
      ram_cmd.strobe |-> ram_cmd.addr == cur_req.addr[addr_bits-1:2])
      else value_error("ram_cmd.addr", $sampled(cur_req.addr[addr_bits-1:2]),
                       $sampled(ram_cmd.addr));

   // the ram strobe is a single cycle pulse
   a_ram_strobe: assert property (@(posedge clk_128) disable iff (!rst_n)
      ram_cmd.strobe |=> !ram_cmd.strobe)
      else value_error("ram_cmd.strobe", 0, $sampled(ram_cmd.strobe));

   initial begin
      logic [addr_bits-1:0] a;
      logic [31:0]          r;
      int                   i;
      clk_128     = 1'b0;
      rst_n       = 1'b0;
      flush       = 1'b0;
      req         = 1'b0;
      req_data    = '0;
      cur_req     = '0;
      cur_kind    = any_latency;
      cur_exp     = '0;
      model_valid = '0;
      repeat (2) @(posedge clk_128);
      #1;
      rst_n = 1'b1;

      // cold read, then warm reads of the same line
      read_word(23'h000104);
      read_word(23'h000104);
      read_word(23'h000107);

      // index 5 under tags 1 and 2 keeps evicting the other line
      for (i = 0; i < 2; i++) begin
         read_word(23'h000114);
         read_word(23'h000216);
      end

      // byte strobes on a cached word, each read back should hit
      read_word(23'h000320);
      write_word(23'h000320, 2'b01, 16'ha1b2);
      read_word(23'h000320);
      write_word(23'h000320, 2'b10, 16'hc3d4);
      read_word(23'h000320);
      write_word(23'h000320, 2'b11, 16'he5f6);
      read_word(23'h000320);

      // writes to words not in the cache come back through a miss
      write_word(23'h004a11, 2'b10, 16'h3c4d);
      read_word(23'h004a11);
      write_word(23'h005b22, 2'b01, 16'h7e8f);
      read_word(23'h005b22);

      // the warm line from the start has to miss after a flush
      pulse_flush();
      read_word(23'h000104);
      read_word(23'h000104);

      // small address pool so that hits, conflicts and write merges mix
      for (i = 0; i < 120; i++) begin
         r = $random(seed);
         a = {13'd0, r[6:5], 4'd0, r[8:7], r[10:9]};
         if (r[4:0] == 5'd0) begin
            pulse_flush();
         end else if (r[1:0] == 2'd0) begin
            write_word(a, (r[12:11] == 2'b00) ? 2'b11 : r[12:11], r[31:16]);
         end else begin
            read_word(a);
         end
      end

      repeat (2) @(posedge clk_128);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== testbench/ram_model.sv ====
`timescale 1ns/1ns

module ram_model (
   input  logic                clk_128,
   input  cache_pkg::ram_req_t ram_cmd,
   output logic                ram_ack,
   output logic [63:0]         ram_rdata
);
   import cache_pkg::*;

   // only words that were written are kept, the rest follow the address formula
   logic [15:0] written [logic [addr_bits-1:0]];
   integer      seed = 32'he648;
   ram_req_t    cmd;
   int          delay;
   logic [15:0] old;

   function automatic logic [15:0] word_at(input logic [addr_bits-1:0] a);
      if (written.exists(a)) begin
         return written[a];
      end
      return a[15:0] ^ 16'h5a5a;
   endfunction

   // one command at a time, answered 1 to 8 cycles after the strobe is seen
   initial begin
      ram_ack   = 1'b0;
      ram_rdata = '0;
      forever begin
         @(posedge clk_128);
         if (ram_cmd.strobe === 1'b1) begin
            cmd   = ram_cmd;
            delay = ({$random(seed)} % 8) + 1;
            repeat (delay - 1) @(posedge clk_128);
            #1;
            if (cmd.op == ram_read_line) begin
               // word 0 sits in the low 16 bits of the line
               for (int w = 0; w < 4; w++) begin
                  ram_rdata[16*w +: 16] = word_at({cmd.addr, w[1:0]});
               end
            end else begin
               // ds bit 0 enables the upper byte and ds bit 1 the lower byte
               old = word_at({cmd.addr, cmd.word});
               written[{cmd.addr, cmd.word}] = {cmd.ds[0] ? cmd.wdata[15:8] : old[15:8],
                                                cmd.ds[1] ? cmd.wdata[7:0] : old[7:0]};
            end
            ram_ack = 1'b1;
            @(posedge clk_128);
            #1;
            ram_ack = 1'b0;
         end
      end
   end

endmodule
